/* all.f */
dbg_pkg.sv
uart_rx.sv
uart_tx.sv
dbg_cmd_engine.sv
uart_dbg_bridge.sv
dbg_properties.sv
dbg_checker.sv
tb_uart_dbg_bridge.sv

/* run.sh */
#!/bin/sh
# Build and run the UART debug bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_uart_dbg_bridge -f all.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "^Regression passed$"

/* tb_uart_dbg_bridge.sv */
/*
 * Testbench top: clock, reset, UART host stimulus, APB memory model
 * with random wait states, command sequence and final report
 */

module tb_uart_dbg_bridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned clks_per_bit  = 8;
  localparam int          clk_period    = 10;
  localparam int          reply_timeout = 20000;
  localparam logic [31:0] err_limit     = 32'h0000_00F0;

  logic              clk;
  logic              rst_n;
  logic              rxd;
  logic              txd;
  dbg_pkg::apb_req_t apb_req;
  dbg_pkg::apb_rsp_t apb_rsp;
  integer            seed = 32'h1d14_8392;
  int                timeouts = 0;
  int                wait_left;
  int                len;
  logic [31:0]       addr;
  logic [7:0]        mem [256];

  uart_dbg_bridge #(
    .ClksPerBit ( clks_per_bit )
  ) uart_dbg_bridge_i (
    .clk       ( clk     ),
    .rst_n_i   ( rst_n   ),
    .uart_rx_i ( rxd     ),
    .uart_tx_o ( txd     ),
    .apb_req_o ( apb_req ),
    .apb_rsp_i ( apb_rsp )
  );

  dbg_checker #(
    .ClksPerBit ( clks_per_bit ),
    .ErrLimit   ( err_limit    )
  ) dbg_checker_i (
    .clk       ( clk     ),
    .rst_n_i   ( rst_n   ),
    .txd_i     ( txd     ),
    .apb_req_i ( apb_req )
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // APB memory model
  ////////////////////////////////////////////////////////////

  task automatic serve_apb();
    logic [7:0] idx;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = (apb_req.paddr >= err_limit);
    for (int k = 0; k < 4; k++) begin
      idx = {apb_req.paddr[7:2], 2'(k)};
      if (apb_req.pwrite && apb_req.pstrb[k] && !apb_rsp.pslverr) begin
        mem[idx] = apb_req.pwdata[8*k +: 8];
      end
      apb_rsp.prdata[8*k +: 8] = apb_rsp.pslverr ? 8'h00 : mem[idx];
    end
  endtask

  initial begin
    apb_rsp = '0;
    wait_left = 0;
    for (int a = 0; a < 256; a++) mem[a] = 8'((a * 37) + 91);
    forever begin
      @(posedge clk);
      #1;
      apb_rsp.pready  = 1'b0;
      apb_rsp.pslverr = 1'b0;
      // Wait states are drawn in the setup cycle
      if (apb_req.psel && !apb_req.penable) begin
        wait_left = $random(seed) & 3;
      end else if (apb_req.psel && apb_req.penable) begin
        if (wait_left > 0) wait_left--;
        else serve_apb();
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // UART host
  ////////////////////////////////////////////////////////////

  // Starts and ends 1 ns after a rising edge
  task automatic send_frame(input logic [7:0] b, input logic stop);
    logic [9:0] frame;
    frame = {stop, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd = frame[i];
      repeat (clks_per_bit) @(posedge clk);
      #1;
    end
    rxd = 1'b1;
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic wait_replies(input string what);
    int n;
    n = 0;
    while (dbg_checker_i.pending() != 0 && n < reply_timeout) begin
      @(posedge clk);
      n++;
    end
    if (dbg_checker_i.pending() != 0) begin
      $display("Timeout at %0t: reply to %s never completed", $time, what);
      timeouts++;
      dbg_checker_i.drop_pending();
    end
    // Rest of the last stop bit
    repeat (clks_per_bit) @(posedge clk);
    #1;
    dbg_checker_i.check_xfers();
  endtask

  task automatic challenge();
    dbg_checker_i.start_command(0);
    send_frame(dbg_pkg::dbg_ack, 1'b1);
    wait_replies("ACK challenge");
  endtask

  task automatic run_cmd(input logic [7:0] op, input logic [31:0] base, input int n);
    logic [7:0]  data [$];
    logic [15:0] len16;
    logic        wr;
    wr    = (op == dbg_pkg::dbg_cmd_write);
    len16 = 16'(n);
    for (int i = 0; i < n; i++) data.push_back(wr ? 8'($random(seed)) : 8'h00);
    dbg_checker_i.start_command(n);
    for (int i = 0; i < n; i++) dbg_checker_i.model_byte(wr, base + 32'(i), data[i]);
    dbg_checker_i.close_command();
    send_frame(op, 1'b1);
    for (int i = 0; i < dbg_pkg::addr_bytes; i++) send_frame(base[8*i +: 8], 1'b1);
    for (int i = 0; i < dbg_pkg::len_bytes; i++) send_frame(len16[8*i +: 8], 1'b1);
    if (wr) begin
      foreach (data[i]) send_frame(data[i], 1'b1);
    end
    wait_replies(wr ? "write command" : "read command");
  endtask

  initial begin
    rst_n = 1'b0;
    rxd   = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    challenge();
    // Write then read back random ranges below the error limit
    for (int r = 0; r < 3; r++) begin
      addr = $random(seed) & 32'h7F;
      len  = 1 + ($random(seed) & 15);
      run_cmd(dbg_pkg::dbg_cmd_write, addr, len);
      run_cmd(dbg_pkg::dbg_cmd_read, addr, len);
    end
    // Unaligned, odd lengths across word boundaries
    run_cmd(dbg_pkg::dbg_cmd_read, 32'h0000_0041, 7);
    run_cmd(dbg_pkg::dbg_cmd_read, 32'h0000_008E, 5);
    run_cmd(dbg_pkg::dbg_cmd_read, 32'h0000_0003, 3);
    run_cmd(dbg_pkg::dbg_cmd_read, 32'h0000_0010, 0);
    run_cmd(dbg_pkg::dbg_cmd_write, 32'h0000_0020, 0);
    // Ranges that cross into the slave error region
    run_cmd(dbg_pkg::dbg_cmd_write, 32'h0000_00EC, 6);
    run_cmd(dbg_pkg::dbg_cmd_read, 32'h0000_00EA, 8);
    // Unknown byte and a frame with a low stop bit get no reply
    send_frame(8'h55, 1'b1);
    send_frame(dbg_pkg::dbg_ack, 1'b0);
    repeat (20 * clks_per_bit) @(posedge clk);
    #1;
    challenge();
    $display("Replies checked %0d, mismatches %0d, transfer errors %0d, line errors %0d, timeouts %0d",
             dbg_checker_i.checks, dbg_checker_i.mismatches, dbg_checker_i.xfer_errs,
             dbg_checker_i.line_errs, timeouts);
    if (dbg_checker_i.mismatches + dbg_checker_i.xfer_errs + dbg_checker_i.line_errs
        + timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* dbg_checker.sv */
/*
 * Reply monitor: decodes frames on the tx line, holds the shadow memory
 * reference model and compares reply bytes and APB transfer counts
 */

module dbg_checker #(
  parameter int unsigned ClksPerBit = 8,
  parameter logic [31:0] ErrLimit   = 32'h0000_00F0
) (
  input logic              clk,
  input logic              rst_n_i,
  input logic              txd_i,
  input dbg_pkg::apb_req_t apb_req_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] shadow [256];
  logic [7:0] exp_q [$];
  logic       cmd_err = 1'b0;
  int         xfer_total = 0;
  int         xfer_base = 0;
  int         xfer_exp = 0;
  int         checks = 0;
  int         mismatches = 0;
  int         xfer_errs = 0;
  int         line_errs = 0;
  logic       busy = 1'b0;
  int         bit_idx = 0;
  int         cnt = 0;
  logic [7:0] shift = 8'h00;
  logic [7:0] exp_byte;

  // Same fill rule as the memory model
  initial begin
    for (int a = 0; a < 256; a++) shadow[a] = 8'((a * 37) + 91);
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Byte seen by a transfer at addr; slave errors read as zero
  function automatic logic [7:0] dbg_expect(input logic wr, input logic [31:0] addr,
                                            input logic [7:0] wbyte);
    if (addr >= ErrLimit) begin
      cmd_err = 1'b1;
      return 8'h00;
    end
    if (wr) shadow[addr[7:0]] = wbyte;
    return shadow[addr[7:0]];
  endfunction

  function automatic void start_command(input int len);
    exp_q.push_back(dbg_pkg::dbg_ack);
    cmd_err   = 1'b0;
    xfer_exp  = len;
    xfer_base = xfer_total;
  endfunction

  function automatic void model_byte(input logic wr, input logic [31:0] addr,
                                     input logic [7:0] wbyte);
    logic [7:0] b;
    b = dbg_expect(wr, addr, wbyte);
    if (!wr) exp_q.push_back(b);
  endfunction

  function automatic void close_command();
    exp_q.push_back(cmd_err ? dbg_pkg::dbg_nak : dbg_pkg::dbg_eot);
  endfunction

  function automatic int pending();
    return exp_q.size();
  endfunction

  function automatic void drop_pending();
    exp_q.delete();
  endfunction

  function automatic void check_xfers();
    if (xfer_total - xfer_base != xfer_exp) begin
      $display("MISMATCH at %0t: %0d APB transfers seen, %0d expected",
               $time, xfer_total - xfer_base, xfer_exp);
      xfer_errs++;
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Frame decoder on the falling clock edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n_i) begin
      busy = 1'b0;
    end else begin
      if (apb_req_i.psel && !apb_req_i.penable) xfer_total++;
      if (!busy) begin
        if (!txd_i) begin
          busy    = 1'b1;
          bit_idx = 0;
          cnt     = ClksPerBit / 2;
        end
      end else if (cnt != 0) begin
        cnt--;
      end else begin
        cnt = ClksPerBit - 1;
        if (bit_idx == 0 && txd_i) begin
          $display("Start bit on the tx line ended early at %0t", $time);
          line_errs++;
          busy = 1'b0;
        end else if (bit_idx >= 1 && bit_idx <= 8) begin
          shift = {txd_i, shift[7:1]};
        end else if (bit_idx == 9) begin
          busy = 1'b0;
          if (!txd_i) begin
            $display("Reply frame at %0t has a low stop bit", $time);
            line_errs++;
          end else if (exp_q.size() == 0) begin
            $display("Unexpected reply frame %02h at %0t", shift, $time);
            line_errs++;
          end else begin
            exp_byte = exp_q.pop_front();
            checks++;
            if (shift != exp_byte) begin
              $display("MISMATCH at %0t: reply byte %02h, expected %02h",
                       $time, shift, exp_byte);
              mismatches++;
            end
          end
        end
        bit_idx++;
      end
    end
  end

endmodule

/* dbg_properties.sv */
/*
 * Concurrent assertions on the APB requester and reply stream
 * of the command engine, with the bind into it
 */

module dbg_properties (
  input logic              clk,
  input logic              rst_n_i,
  input dbg_pkg::apb_req_t apb_req_i,
  input dbg_pkg::apb_rsp_t apb_rsp_i,
  input logic              tx_valid_i,
  input logic              tx_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Address and direction hold until the completer answers
  assert property (@(posedge clk) disable iff (!rst_n_i)
    apb_req_i.psel && !apb_rsp_i.pready |=>
      $stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite))
    else $error("APB address or direction changed inside a transfer");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(apb_req_i.penable) |-> $past(apb_req_i.psel && !apb_req_i.penable))
    else $error("APB access phase without a setup cycle");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i)
    else $error("Reply byte withdrawn before the transmitter took it");

endmodule

bind dbg_cmd_engine dbg_properties dbg_properties_i (
  .clk        ( clk        ),
  .rst_n_i    ( rst_n_i    ),
  .apb_req_i  ( apb_req_o  ),
  .apb_rsp_i  ( apb_rsp_i  ),
  .tx_valid_i ( tx_valid_o ),
  .tx_ready_i ( tx_ready_i )
);

/* uart_dbg_bridge.sv */
/*
 * UART debug bridge top: serial receiver, command engine with
 * APB requester port, serial transmitter
 */

module uart_dbg_bridge #(
  parameter int unsigned ClksPerBit = 868
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              uart_rx_i,
  output logic              uart_tx_o,
  output dbg_pkg::apb_req_t apb_req_o,
  input  dbg_pkg::apb_rsp_t apb_rsp_i
);

  dbg_pkg::rx_byte_t rx_byte;
  logic [7:0]        tx_data;
  logic              tx_valid;
  logic              tx_ready;

  uart_rx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_rx (
    .clk       ( clk       ),
    .rst_n_i   ( rst_n_i   ),
    .rxd_i     ( uart_rx_i ),
    .rx_byte_o ( rx_byte   )
  );

  dbg_cmd_engine i_dbg_cmd_engine (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .rx_byte_i  ( rx_byte   ),
    .tx_data_o  ( tx_data   ),
    .tx_valid_o ( tx_valid  ),
    .tx_ready_i ( tx_ready  ),
    .apb_req_o  ( apb_req_o ),
    .apb_rsp_i  ( apb_rsp_i )
  );

  uart_tx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_tx (
    .clk        ( clk       ),
    .rst_n_i    ( rst_n_i   ),
    .tx_data_i  ( tx_data   ),
    .tx_valid_i ( tx_valid  ),
    .tx_ready_o ( tx_ready  ),
    .txd_o      ( uart_tx_o )
  );

endmodule

/* dbg_cmd_engine.sv */
/*
 * Debug command FSM: decodes ACK challenge, read and write commands,
 * runs byte-wide APB transfers and sequences the reply bytes
 */

module dbg_cmd_engine (
  input  logic              clk,
  input  logic              rst_n_i,
  input  dbg_pkg::rx_byte_t rx_byte_i,
  output logic [7:0]        tx_data_o,
  output logic              tx_valid_o,
  input  logic              tx_ready_i,
  output dbg_pkg::apb_req_t apb_req_o,
  input  dbg_pkg::apb_rsp_t apb_rsp_i
);

  localparam int unsigned addr_w    = 8 * dbg_pkg::addr_bytes;
  localparam int unsigned len_w     = 8 * dbg_pkg::len_bytes;
  localparam int unsigned hdr_bytes = dbg_pkg::addr_bytes + dbg_pkg::len_bytes;
  localparam int unsigned cnt_w     = $clog2(hdr_bytes);

  dbg_pkg::engine_state_e state_q, state_d;

  logic [addr_w-1:0] addr_q;
  logic [len_w-1:0]  len_q;
  logic [cnt_w-1:0]  hdr_cnt_q;
  logic              wr_q;
  logic              err_q;
  logic [7:0]        wbyte_q;
  logic [7:0]        rbyte_q;
  logic [1:0]        lane;
  logic              xfer_done;

  assign lane      = addr_q[1:0];
  assign xfer_done = (state_q == dbg_pkg::eng_access) && apb_rsp_i.pready;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      dbg_pkg::eng_idle: begin
        // Unknown bytes fall through and are dropped
        if (rx_byte_i.valid) begin
          if (rx_byte_i.data == dbg_pkg::dbg_ack) begin
            state_d = dbg_pkg::eng_echo;
          end else if (rx_byte_i.data == dbg_pkg::dbg_cmd_read ||
                       rx_byte_i.data == dbg_pkg::dbg_cmd_write) begin
            state_d = dbg_pkg::eng_header;
          end
        end
      end
      dbg_pkg::eng_header: begin
        if (rx_byte_i.valid && hdr_cnt_q == cnt_w'(hdr_bytes - 1)) begin
          state_d = dbg_pkg::eng_ack;
        end
      end
      dbg_pkg::eng_echo: begin
        if (tx_ready_i) state_d = dbg_pkg::eng_idle;
      end
      dbg_pkg::eng_ack: begin
        if (tx_ready_i) begin
          if (len_q == '0) state_d = dbg_pkg::eng_close;
          else if (wr_q)   state_d = dbg_pkg::eng_wdata;
          else             state_d = dbg_pkg::eng_setup;
        end
      end
      dbg_pkg::eng_wdata: begin
        if (rx_byte_i.valid) state_d = dbg_pkg::eng_setup;
      end
      dbg_pkg::eng_setup: begin
        state_d = dbg_pkg::eng_access;
      end
      dbg_pkg::eng_access: begin
        if (apb_rsp_i.pready) begin
          if (!wr_q)                    state_d = dbg_pkg::eng_rdata;
          else if (len_q == len_w'(1)) state_d = dbg_pkg::eng_close;
          else                          state_d = dbg_pkg::eng_wdata;
        end
      end
      dbg_pkg::eng_rdata: begin
        // Length already counted down at the end of the transfer
        if (tx_ready_i) begin
          state_d = (len_q == '0) ? dbg_pkg::eng_close : dbg_pkg::eng_setup;
        end
      end
      dbg_pkg::eng_close: begin
        if (tx_ready_i) state_d = dbg_pkg::eng_idle;
      end
      default: state_d = dbg_pkg::eng_idle;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control and payload registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= dbg_pkg::eng_idle;
      hdr_cnt_q <= '0;
      wr_q      <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == dbg_pkg::eng_idle && rx_byte_i.valid) begin
        hdr_cnt_q <= '0;
        wr_q      <= (rx_byte_i.data == dbg_pkg::dbg_cmd_write);
        err_q     <= 1'b0;
      end
      if (state_q == dbg_pkg::eng_header && rx_byte_i.valid) begin
        hdr_cnt_q <= hdr_cnt_q + 1'b1;
      end
      // Sticky until the next command, turns EOT into NAK
      if (xfer_done && apb_rsp_i.pslverr) err_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    // Header bytes shift in from the top, address first
    if (state_q == dbg_pkg::eng_header && rx_byte_i.valid) begin
      {len_q, addr_q} <= {rx_byte_i.data, len_q, addr_q[addr_w-1:8]};
    end
    if (state_q == dbg_pkg::eng_wdata && rx_byte_i.valid) begin
      wbyte_q <= rx_byte_i.data;
    end
    if (xfer_done) begin
      rbyte_q <= apb_rsp_i.prdata[8*lane +: 8];
      addr_q  <= addr_q + 1'b1;
      len_q   <= len_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reply stream and APB request
  ////////////////////////////////////////////////////////////

  assign tx_valid_o = (state_q == dbg_pkg::eng_echo)  || (state_q == dbg_pkg::eng_ack) ||
                      (state_q == dbg_pkg::eng_rdata) || (state_q == dbg_pkg::eng_close);

  always_comb begin
    unique case (state_q)
      dbg_pkg::eng_rdata: tx_data_o = rbyte_q;
      dbg_pkg::eng_close: tx_data_o = err_q ? dbg_pkg::dbg_nak : dbg_pkg::dbg_eot;
      default:            tx_data_o = dbg_pkg::dbg_ack;
    endcase
  end

  always_comb begin
    apb_req_o.paddr   = addr_q;
    apb_req_o.psel    = (state_q == dbg_pkg::eng_setup) || (state_q == dbg_pkg::eng_access);
    apb_req_o.penable = (state_q == dbg_pkg::eng_access);
    apb_req_o.pwrite  = wr_q;
    // Byte repeated on every lane, strobe picks the one addressed
    apb_req_o.pwdata  = {4{wbyte_q}};
    apb_req_o.pstrb   = wr_q ? (4'b0001 << lane) : 4'b0000;
  end

endmodule

/* uart_tx.sv */
/*
 * 8N1 UART transmitter with a ready/valid byte input
 */

module uart_tx #(
  parameter int unsigned ClksPerBit
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic [7:0] tx_data_i,
  input  logic       tx_valid_i,
  output logic       tx_ready_o,
  output logic       txd_o
);

  localparam int unsigned cnt_w = $clog2(ClksPerBit + 1);
  localparam logic [cnt_w-1:0] cnt_bit = cnt_w'(ClksPerBit - 1);

  logic             busy_q;
  logic [3:0]       bit_idx_q;
  logic [cnt_w-1:0] baud_cnt_q;
  logic [9:0]       frame_q;

  assign tx_ready_o = !busy_q;

  // Frame shifts out from bit 0 and fills with ones, so the idle line stays high
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      bit_idx_q  <= '0;
      baud_cnt_q <= '0;
      frame_q    <= '1;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        busy_q     <= 1'b1;
        bit_idx_q  <= '0;
        baud_cnt_q <= cnt_bit;
        frame_q    <= {1'b1, tx_data_i, 1'b0};
      end
    end else if (baud_cnt_q != '0) begin
      baud_cnt_q <= baud_cnt_q - 1'b1;
    end else begin
      baud_cnt_q <= cnt_bit;
      frame_q    <= {1'b1, frame_q[9:1]};
      if (bit_idx_q == 4'd9) begin
        // Stop bit done
        busy_q <= 1'b0;
      end else begin
        bit_idx_q <= bit_idx_q + 1'b1;
      end
    end
  end

  assign txd_o = frame_q[0];

endmodule

/* uart_rx.sv */
/*
 * 8N1 UART receiver with two-flop input synchronizer,
 * mid-bit sampling and stop bit check
 */

module uart_rx #(
  parameter int unsigned ClksPerBit
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              rxd_i,
  output dbg_pkg::rx_byte_t rx_byte_o
);

  localparam int unsigned cnt_w = $clog2(ClksPerBit + 1);
  localparam logic [cnt_w-1:0] cnt_bit  = cnt_w'(ClksPerBit - 1);
  localparam logic [cnt_w-1:0] cnt_half = cnt_w'(ClksPerBit / 2 - 1);

  logic             rxd_meta_q;
  logic             rxd_sync_q;
  logic             rxd_prev_q;
  logic             busy_q;
  logic [3:0]       bit_idx_q;
  logic [cnt_w-1:0] baud_cnt_q;
  logic [7:0]       shift_q;
  logic             valid_q;

  // Bit index 0 is the start bit, 1 to 8 data, 9 the stop bit
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      rxd_meta_q <= 1'b1;
      rxd_sync_q <= 1'b1;
      rxd_prev_q <= 1'b1;
      busy_q     <= 1'b0;
      bit_idx_q  <= '0;
      baud_cnt_q <= '0;
      valid_q    <= 1'b0;
    end else begin
      rxd_meta_q <= rxd_i;
      rxd_sync_q <= rxd_meta_q;
      rxd_prev_q <= rxd_sync_q;
      valid_q    <= 1'b0;
      if (!busy_q) begin
        // Falling edge starts a frame
        if (rxd_prev_q && !rxd_sync_q) begin
          busy_q     <= 1'b1;
          bit_idx_q  <= '0;
          baud_cnt_q <= cnt_half;
        end
      end else if (baud_cnt_q != '0) begin
        baud_cnt_q <= baud_cnt_q - 1'b1;
      end else begin
        baud_cnt_q <= cnt_bit;
        bit_idx_q  <= bit_idx_q + 1'b1;
        if (bit_idx_q == 4'd0) begin
          // Glitch, start bit gone by mid-bit
          if (rxd_sync_q) busy_q <= 1'b0;
        end else if (bit_idx_q == 4'd9) begin
          busy_q  <= 1'b0;
          valid_q <= rxd_sync_q;
        end
      end
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (busy_q && baud_cnt_q == '0 && bit_idx_q >= 4'd1 && bit_idx_q <= 4'd8) begin
      shift_q <= {rxd_sync_q, shift_q[7:1]};
    end
  end

  assign rx_byte_o.valid = valid_q;
  assign rx_byte_o.data  = shift_q;

endmodule

/* dbg_pkg.sv */
/*
 * Shared definitions of the UART debug bridge: protocol byte codes,
 * header field sizes, APB and received-byte structs, engine states
 */

package dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Protocol byte codes
  ////////////////////////////////////////////////////////////

  localparam logic [7:0] dbg_ack       = 8'h06;
  localparam logic [7:0] dbg_cmd_read  = 8'h11;
  localparam logic [7:0] dbg_cmd_write = 8'h12;
  localparam logic [7:0] dbg_eot       = 8'h04;
  localparam logic [7:0] dbg_nak       = 8'h15;

  // Header field sizes in bytes, both little-endian
  localparam int unsigned addr_bytes = 4;
  localparam int unsigned len_bytes  = 2;

  ////////////////////////////////////////////////////////////
  // Bus and stream structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Valid is a single-cycle pulse
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

  typedef enum logic [3:0] {
    eng_idle,
    eng_echo,
    eng_header,
    eng_ack,
    eng_wdata,
    eng_setup,
    eng_access,
    eng_rdata,
    eng_close
  } engine_state_e;

endpackage
